// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  // Word and register file geometry
  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;

  //////////////////////////////////////////////////
  // Instruction field positions
  //////////////////////////////////////////////////
  localparam int OPCODE_WIDTH   = 7;
  localparam int FUNCT3_WIDTH   = 3;
  localparam int RD_LSB         = 7;
  localparam int FUNCT3_LSB     = 12;
  localparam int RS1_LSB        = 15;
  localparam int RS2_LSB        = 20;
  localparam int FUNCT7_ALT_BIT = 30;  // SUB/SRA/SRAI selector

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_LOAD  = 7'b000_0011;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_OPIMM = 7'b001_0011;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_AUIPC = 7'b001_0111;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_STORE = 7'b010_0011;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_OP    = 7'b011_0011;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_LUI   = 7'b011_0111;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_JAL   = 7'b110_1111;

  // Low funct3 bits shared by SLLI (001) and SRLI/SRAI (101)
  localparam logic [1:0] FUNCT3_SHIFT = 2'b01;

endpackage

// File: src/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  //////////////////////////////////////////////////
  // ALU and LSU control
  //////////////////////////////////////////////////
  localparam int ALU_OP_WIDTH = 4;  // {funct7[5], funct3}
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OP_ADD = 4'b0000;

  // Opcode bit 6 followed by funct3
  localparam int LSU_CTRL_WIDTH = 4;

  //////////////////////////////////////////////////
  // Decode stage enumerations
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    IMM_I,
    IMM_SHIFT,
    IMM_S,
    IMM_U,
    IMM_J,
    IMM_FOUR,   // Link address offset for JAL
    IMM_ZERO
  } imm_fmt_e;

  typedef enum logic [1:0] {
    ST_OK,
    ST_STALL,   // RAW hazard, one bubble
    ST_JAL,
    ST_ERROR
  } dec_state_e;

endpackage

// File: src/dec_ctrl_if.sv
interface dec_ctrl_if import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

  logic [ALU_OP_WIDTH-1:0]   alu_sel;
  logic                      use_rs1;
  logic                      use_rs2;
  logic [REG_ADDR_WIDTH-1:0] rs1;
  logic [REG_ADDR_WIDTH-1:0] rs2;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic                      alu_wb;   // Result goes to rd
  logic                      use_pc;   // Operand A is the PC
  logic                      lsu_new;
  logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl;
  imm_fmt_e                  imm_fmt;
  logic                      illegal;

  modport dec (
    output alu_sel, use_rs1, use_rs2, rs1, rs2, rd, alu_wb,
    output use_pc, lsu_new, lsu_ctrl, imm_fmt, illegal
  );

  // Hazard tracking only looks at register usage
  modport hzd (
    input rs1, rs2, use_rs1, use_rs2, rd, alu_wb, lsu_new, illegal
  );

  modport iss (
    input alu_sel, use_rs1, use_rs2, rs1, rs2, rd, alu_wb,
    input use_pc, lsu_new, lsu_ctrl, imm_fmt, illegal
  );

endinterface

// File: src/imm_gen.sv
module imm_gen import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic [DATA_WIDTH-1:0] instr_i,
  input  imm_fmt_e              fmt_i,
  output logic [DATA_WIDTH-1:0] imm_o
);

  logic                  sign;
  logic [DATA_WIDTH-1:0] imm_i_fmt;
  logic [DATA_WIDTH-1:0] imm_shift_fmt;
  logic [DATA_WIDTH-1:0] imm_s_fmt;
  logic [DATA_WIDTH-1:0] imm_u_fmt;
  logic [DATA_WIDTH-1:0] imm_j_fmt;

  assign sign = instr_i[DATA_WIDTH-1];

  assign imm_i_fmt     = {{(DATA_WIDTH-12){sign}}, instr_i[31:20]};
  assign imm_shift_fmt = {{(DATA_WIDTH-5){1'b0}}, instr_i[24:20]};  // shamt
  assign imm_s_fmt     = {{(DATA_WIDTH-12){sign}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_fmt     = {instr_i[31:12], 12'b0};

  // J offset is scrambled in the encoding, bit 0 always zero
  assign imm_j_fmt = {{(DATA_WIDTH-20){sign}}, instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};

  always_comb begin
    unique case (fmt_i)
      IMM_I:     imm_o = imm_i_fmt;
      IMM_SHIFT: imm_o = imm_shift_fmt;
      IMM_S:     imm_o = imm_s_fmt;
      IMM_U:     imm_o = imm_u_fmt;
      IMM_J:     imm_o = imm_j_fmt;
      IMM_FOUR:  imm_o = DATA_WIDTH'(4);
      default:   imm_o = '0;             // IMM_ZERO
    endcase
  end

endmodule

// File: src/opcode_decoder.sv
module opcode_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic [DATA_WIDTH-1:0] instr_i,
  dec_ctrl_if.dec               ctrl
);

  logic [OPCODE_WIDTH-1:0] opcode;
  logic [FUNCT3_WIDTH-1:0] funct3;
  logic                    alt_bit;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////
  assign opcode  = instr_i[OPCODE_WIDTH-1:0];
  assign funct3  = instr_i[FUNCT3_LSB +: FUNCT3_WIDTH];
  assign alt_bit = instr_i[FUNCT7_ALT_BIT];

  // Register fields pass straight through, the use flags qualify them
  assign ctrl.rs1      = instr_i[RS1_LSB +: REG_ADDR_WIDTH];
  assign ctrl.rs2      = instr_i[RS2_LSB +: REG_ADDR_WIDTH];
  assign ctrl.rd       = instr_i[RD_LSB +: REG_ADDR_WIDTH];
  assign ctrl.lsu_ctrl = {opcode[6], funct3};

  //////////////////////////////////////////////////
  // Opcode to control bundle
  //////////////////////////////////////////////////
  always_comb begin
    ctrl.alu_sel = ALU_OP_ADD;
    ctrl.use_rs1 = 1'b0;
    ctrl.use_rs2 = 1'b0;
    ctrl.alu_wb  = 1'b0;
    ctrl.use_pc  = 1'b0;
    ctrl.lsu_new = 1'b0;
    ctrl.imm_fmt = IMM_ZERO;
    ctrl.illegal = 1'b0;

    unique case (opcode)
      OPCODE_OP: begin
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        ctrl.alu_wb  = 1'b1;
        ctrl.alu_sel = {alt_bit, funct3};
      end
      OPCODE_OPIMM: begin
        ctrl.use_rs1 = 1'b1;
        ctrl.alu_wb  = 1'b1;
        if (funct3[1:0] == FUNCT3_SHIFT) begin
          ctrl.imm_fmt = IMM_SHIFT;
          ctrl.alu_sel = {alt_bit, funct3};  // SRAI vs SRLI
        end else begin
          ctrl.imm_fmt = IMM_I;
          ctrl.alu_sel = {1'b0, funct3};
        end
      end
      OPCODE_LUI: begin
        ctrl.alu_wb  = 1'b1;
        ctrl.imm_fmt = IMM_U;
      end
      OPCODE_AUIPC: begin
        ctrl.alu_wb  = 1'b1;
        ctrl.use_pc  = 1'b1;
        ctrl.imm_fmt = IMM_U;
      end
      OPCODE_LOAD: begin
        ctrl.use_rs1 = 1'b1;
        ctrl.lsu_new = 1'b1;
        ctrl.imm_fmt = IMM_I;
      end
      OPCODE_STORE: begin
        ctrl.use_rs1 = 1'b1;
        ctrl.lsu_new = 1'b1;
        ctrl.imm_fmt = IMM_S;
      end
      OPCODE_JAL: begin
        ctrl.use_pc  = 1'b1;   // rd = PC + 4
        ctrl.alu_wb  = 1'b1;
        ctrl.imm_fmt = IMM_FOUR;
      end
      default: begin
        ctrl.illegal = 1'b1;   // Includes BRANCH, JALR, SYSTEM, MISC-MEM
      end
    endcase
  end

endmodule

// File: src/hazard_fsm.sv
module hazard_fsm import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    instr_valid_i,
  input  logic [OPCODE_WIDTH-1:0] opcode_i,
  dec_ctrl_if.hzd                 ctrl,
  input  logic [DATA_WIDTH-1:0]   j_imm_i,
  output logic                    ready_o,
  output logic                    jmp_o,
  output logic [DATA_WIDTH-1:0]   jmp_addr_o,
  output logic                    bubble_o
);

  dec_state_e                state_d;   // State of the presenting cycle
  dec_state_e                state_q;   // State of the previous cycle
  logic [REG_ADDR_WIDTH-1:0] prev_rd;
  logic                      raw_rs1;
  logic                      raw_rs2;
  logic                      writes_rd;

  // x0 never creates a dependency
  assign raw_rs1 = ctrl.use_rs1 && (ctrl.rs1 != '0) && (ctrl.rs1 == prev_rd);
  assign raw_rs2 = ctrl.use_rs2 && (ctrl.rs2 != '0) && (ctrl.rs2 == prev_rd);

  // LSU results are written back outside the ALU path
  assign writes_rd = ctrl.alu_wb && !ctrl.lsu_new;

  //////////////////////////////////////////////////
  // State decision
  //////////////////////////////////////////////////
  always_comb begin
    state_d = ST_OK;
    if (instr_valid_i) begin
      if (ctrl.illegal) begin
        state_d = ST_ERROR;
      end else if (opcode_i == OPCODE_JAL) begin
        state_d = ST_JAL;
      end else if ((raw_rs1 || raw_rs2) && (state_q != ST_STALL)) begin
        state_d = ST_STALL;                  // Only ever one stall in a row
      end
    end
  end

  always_comb begin
    ready_o    = 1'b1;
    jmp_o      = 1'b0;
    jmp_addr_o = '0;
    bubble_o   = 1'b0;
    unique case (state_d)
      ST_STALL: begin
        ready_o  = 1'b0;
        bubble_o = 1'b1;
      end
      ST_JAL: begin
        jmp_o      = 1'b1;
        jmp_addr_o = j_imm_i;
      end
      ST_ERROR: ready_o = 1'b0;              // Hold the fetch unit
      default:  ready_o = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // State and previous destination
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= ST_OK;
      prev_rd <= '0;
    end else begin
      state_q <= state_d;
      if (instr_valid_i && ready_o && writes_rd) begin
        prev_rd <= ctrl.rd;
      end else begin
        prev_rd <= '0;
      end
    end
  end

endmodule

// File: src/issue_reg.sv
module issue_reg import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      instr_valid_i,
  input  logic                      bubble_i,
  dec_ctrl_if.iss                   ctrl,
  input  logic [DATA_WIDTH-1:0]     imm_i,
  output logic                      use_pc_o,
  output logic                      illegal_instr_o,
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      alu_op_a_o,
  output logic                      alu_op_b_o,
  output logic [REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  output logic                      alu_wb_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  output logic                      is_imm_o,
  output logic [DATA_WIDTH-1:0]     imm_ext_o,
  output logic                      lsu_new_ctrl_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output logic [REG_ADDR_WIDTH-1:0] lsu_regdest_o
);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      use_pc_o        <= 1'b0;
      illegal_instr_o <= 1'b0;
      alu_sel_o       <= '0;
      alu_op_a_o      <= 1'b0;
      alu_op_b_o      <= 1'b0;
      alu_dest_addr_o <= '0;
      alu_wb_o        <= 1'b0;
      rf_addr_a_o     <= '0;
      rf_addr_b_o     <= '0;
      is_imm_o        <= 1'b0;
      imm_ext_o       <= '0;
      lsu_new_ctrl_o  <= 1'b0;
      lsu_ctrl_o      <= '0;
      lsu_regdest_o   <= '0;
    end else if (instr_valid_i) begin
      use_pc_o        <= ctrl.use_pc;
      illegal_instr_o <= ctrl.illegal;
      alu_sel_o       <= ctrl.alu_sel;
      alu_op_a_o      <= ctrl.use_rs1;
      alu_op_b_o      <= ctrl.use_rs2;
      alu_dest_addr_o <= ctrl.alu_wb ? ctrl.rd : '0;
      rf_addr_a_o     <= ctrl.use_rs1 ? ctrl.rs1 : '0;
      rf_addr_b_o     <= ctrl.use_rs2 ? ctrl.rs2 : '0;
      is_imm_o        <= !(ctrl.use_rs1 && ctrl.use_rs2);
      imm_ext_o       <= imm_i;
      lsu_ctrl_o      <= ctrl.lsu_ctrl;
      lsu_regdest_o   <= ctrl.rd;
      // A bubble keeps the bundle but must not commit anything
      alu_wb_o        <= ctrl.alu_wb && !bubble_i;
      lsu_new_ctrl_o  <= ctrl.lsu_new && !bubble_i;
    end else begin
      use_pc_o        <= 1'b0;   // Idle, rest holds
      alu_wb_o        <= 1'b0;
      lsu_new_ctrl_o  <= 1'b0;
    end
  end

endmodule

// File: src/rv_decoder.sv
module rv_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,

  // Fetch unit
  input  logic [DATA_WIDTH-1:0]     instr_i,
  input  logic [DATA_WIDTH-1:0]     instr_addr_i,
  input  logic                      instr_valid_i,
  output logic                      ready_o,
  output logic                      jmp_o,
  output logic [DATA_WIDTH-1:0]     jmp_addr_o,
  output logic [DATA_WIDTH-1:0]     instr_addr_o,

  // Issue side
  output logic                      use_pc_o,
  output logic                      illegal_instr_o,
  output logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  output logic                      alu_op_a_o,
  output logic                      alu_op_b_o,
  output logic [REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  output logic                      alu_wb_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  output logic                      is_imm_o,
  output logic [DATA_WIDTH-1:0]     imm_ext_o,
  output logic                      lsu_new_ctrl_o,
  output logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  output logic [REG_ADDR_WIDTH-1:0] lsu_regdest_o
);

  logic [DATA_WIDTH-1:0] stage_imm;
  logic [DATA_WIDTH-1:0] j_imm;      // Jump target offset
  logic                  bubble;

  dec_ctrl_if u_ctrl ();

  opcode_decoder u_opcode_decoder (
    .instr_i (instr_i),
    .ctrl    (u_ctrl.dec)
  );

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////
  imm_gen u_imm_stage (
    .instr_i (instr_i),
    .fmt_i   (u_ctrl.imm_fmt),
    .imm_o   (stage_imm)
  );

  imm_gen u_imm_jump (
    .instr_i (instr_i),
    .fmt_i   (IMM_J),
    .imm_o   (j_imm)
  );

  hazard_fsm u_hazard_fsm (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .opcode_i      (instr_i[OPCODE_WIDTH-1:0]),
    .ctrl          (u_ctrl.hzd),
    .j_imm_i       (j_imm),
    .ready_o       (ready_o),
    .jmp_o         (jmp_o),
    .jmp_addr_o    (jmp_addr_o),
    .bubble_o      (bubble)
  );

  issue_reg u_issue_reg (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .instr_valid_i   (instr_valid_i),
    .bubble_i        (bubble),
    .ctrl            (u_ctrl.iss),
    .imm_i           (stage_imm),
    .use_pc_o        (use_pc_o),
    .illegal_instr_o (illegal_instr_o),
    .alu_sel_o       (alu_sel_o),
    .alu_op_a_o      (alu_op_a_o),
    .alu_op_b_o      (alu_op_b_o),
    .alu_dest_addr_o (alu_dest_addr_o),
    .alu_wb_o        (alu_wb_o),
    .rf_addr_a_o     (rf_addr_a_o),
    .rf_addr_b_o     (rf_addr_b_o),
    .is_imm_o        (is_imm_o),
    .imm_ext_o       (imm_ext_o),
    .lsu_new_ctrl_o  (lsu_new_ctrl_o),
    .lsu_ctrl_o      (lsu_ctrl_o),
    .lsu_regdest_o   (lsu_regdest_o)
  );

  // Address follows the instruction into the issue stage
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_addr_o <= '0;
    end else begin
      instr_addr_o <= instr_addr_i;
    end
  end

endmodule

// File: testbench/rv_decoder_chk.sv
module rv_decoder_chk import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input logic                      clk_i,
  input logic                      rstn_i,
  input logic [DATA_WIDTH-1:0]     instr_i,
  input logic [DATA_WIDTH-1:0]     instr_addr_i,
  input logic                      instr_valid_i,
  input logic                      ready_o,
  input logic                      jmp_o,
  input logic [DATA_WIDTH-1:0]     jmp_addr_o,
  input logic [DATA_WIDTH-1:0]     instr_addr_o,
  input logic                      use_pc_o,
  input logic                      illegal_instr_o,
  input logic [ALU_OP_WIDTH-1:0]   alu_sel_o,
  input logic                      alu_op_a_o,
  input logic                      alu_op_b_o,
  input logic [REG_ADDR_WIDTH-1:0] alu_dest_addr_o,
  input logic                      alu_wb_o,
  input logic [REG_ADDR_WIDTH-1:0] rf_addr_a_o,
  input logic [REG_ADDR_WIDTH-1:0] rf_addr_b_o,
  input logic                      is_imm_o,
  input logic [DATA_WIDTH-1:0]     imm_ext_o,
  input logic                      lsu_new_ctrl_o,
  input logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o,
  input logic [REG_ADDR_WIDTH-1:0] lsu_regdest_o
);

  logic [6:0]                opc;
  logic [REG_ADDR_WIDTH-1:0] rs1;
  logic [REG_ADDR_WIDTH-1:0] rs2;
  logic [REG_ADDR_WIDTH-1:0] last_rd;     // Writing rd accepted on the last edge
  logic                      last_stall;
  logic                      accept;
  logic                      hazard;
  logic                      failed;

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////
  function automatic logic is_legal(input logic [6:0] o);
    return o inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
                     OPCODE_LOAD, OPCODE_STORE, OPCODE_JAL};
  endfunction

  function automatic logic writes_rd(input logic [6:0] o);
    return o inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL};
  endfunction

  function automatic logic reads_rs1(input logic [6:0] o);
    return o inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LOAD, OPCODE_STORE};
  endfunction

  function automatic logic [31:0] opimm_imm(input logic [31:0] w);
    if (w[13:12] == 2'b01) begin
      return {27'b0, w[24:20]};                  // Shift amount
    end
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic logic [31:0] mem_imm(input logic [31:0] w);
    if (w[6:0] == OPCODE_STORE) begin
      return {{20{w[31]}}, w[31:25], w[11:7]};
    end
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic logic [31:0] jal_imm(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  task automatic record_failure(input string what);
    $error("FAIL %0t: %s", $time, what);
    failed = 1'b1;
  endtask

  initial failed = 1'b0;

  assign opc    = instr_i[6:0];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign accept = instr_valid_i && ready_o;
  assign hazard = instr_valid_i && !last_stall &&
                  ((reads_rs1(opc) && rs1 != '0 && rs1 == last_rd) ||
                   (opc == OPCODE_OP && rs2 != '0 && rs2 == last_rd));

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd    <= '0;
      last_stall <= 1'b0;
    end else begin
      last_stall <= hazard;
      last_rd    <= (accept && writes_rd(opc)) ? instr_i[11:7] : '0;
    end
  end

  //////////////////////////////////////////////////
  // Decode results
  //////////////////////////////////////////////////
  a_op: assert property (@(posedge clk_i) disable iff (!rstn_i)
    accept && opc == OPCODE_OP |=>
      alu_sel_o == {$past(instr_i[30]), $past(instr_i[14:12])} &&
      rf_addr_a_o == $past(rs1) && rf_addr_b_o == $past(rs2) && alu_wb_o && !is_imm_o &&
      alu_op_a_o && alu_op_b_o && alu_dest_addr_o == $past(instr_i[11:7]))
    else record_failure("OP decode");

  a_opimm: assert property (@(posedge clk_i) disable iff (!rstn_i)
    accept && opc == OPCODE_OPIMM |=>
      imm_ext_o == opimm_imm($past(instr_i)) && is_imm_o &&
      alu_op_a_o && !alu_op_b_o && rf_addr_a_o == $past(rs1) && rf_addr_b_o == '0 &&
      alu_dest_addr_o == $past(instr_i[11:7]))
    else record_failure("OP-IMM immediate");

  a_upper: assert property (@(posedge clk_i) disable iff (!rstn_i)
    accept && (opc == OPCODE_LUI || opc == OPCODE_AUIPC) |=>
      imm_ext_o == {$past(instr_i[31:12]), 12'b0} && is_imm_o &&
      use_pc_o == ($past(opc) == OPCODE_AUIPC))
    else record_failure("LUI/AUIPC immediate");

  a_lsu: assert property (@(posedge clk_i) disable iff (!rstn_i)
    accept && (opc == OPCODE_LOAD || opc == OPCODE_STORE) |=>
      lsu_new_ctrl_o && !alu_wb_o && imm_ext_o == mem_imm($past(instr_i)) &&
      lsu_ctrl_o == {$past(instr_i[6]), $past(instr_i[14:12])} &&
      ($past(opc) == OPCODE_STORE || lsu_regdest_o == $past(instr_i[11:7])))
    else record_failure("LOAD/STORE control");

  // Address register runs every cycle
  a_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rstn_i |=> instr_addr_o == $past(instr_addr_i))
    else record_failure("Instruction address not buffered");

  //////////////////////////////////////////////////
  // Handshake, stall, jump, error
  //////////////////////////////////////////////////
  a_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
    hazard |-> !ready_o ##1 (!alu_wb_o && !lsu_new_ctrl_o))
    else record_failure("RAW hazard without a one-cycle bubble");

  a_retry: assert property (@(posedge clk_i) disable iff (!rstn_i)
    hazard ##1 (instr_valid_i && $stable(instr_i)) |-> ready_o)
    else record_failure("Stalled instruction not accepted on retry");

  a_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i && is_legal(opc) && !hazard |-> ready_o)
    else record_failure("Stage stalled without a hazard");

  a_jal: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i && opc == OPCODE_JAL |->
      (jmp_o && ready_o && jmp_addr_o == jal_imm(instr_i)) ##1
      (use_pc_o && alu_wb_o && imm_ext_o == 32'd4 &&
       alu_dest_addr_o == $past(instr_i[11:7])))
    else record_failure("JAL jump or link");

  a_illegal: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i && !is_legal(opc) |-> !ready_o ##1 illegal_instr_o)
    else record_failure("Illegal opcode handling");

  a_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !instr_valid_i |=> !alu_wb_o && !lsu_new_ctrl_o)
    else record_failure("Commit flags set after an idle cycle");

  a_reset: assert property (@(posedge clk_i) !rstn_i |=> !alu_wb_o && !lsu_new_ctrl_o)
    else record_failure("Commit flags set after reset");

endmodule

bind rv_decoder rv_decoder_chk u_rv_decoder_chk (.*);

// File: testbench/tb_rv_decoder.sv
module tb_rv_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

  logic                      clk_i;
  logic                      rstn_i;
  logic [DATA_WIDTH-1:0]     instr_i;
  logic [DATA_WIDTH-1:0]     instr_addr_i;
  logic                      instr_valid_i;
  logic                      ready_o;
  logic                      jmp_o;
  logic [DATA_WIDTH-1:0]     jmp_addr_o;
  logic [DATA_WIDTH-1:0]     instr_addr_o;
  logic                      use_pc_o;
  logic                      illegal_instr_o;
  logic [ALU_OP_WIDTH-1:0]   alu_sel_o;
  logic                      alu_op_a_o;
  logic                      alu_op_b_o;
  logic [REG_ADDR_WIDTH-1:0] alu_dest_addr_o;
  logic                      alu_wb_o;
  logic [REG_ADDR_WIDTH-1:0] rf_addr_a_o;
  logic [REG_ADDR_WIDTH-1:0] rf_addr_b_o;
  logic                      is_imm_o;
  logic [DATA_WIDTH-1:0]     imm_ext_o;
  logic                      lsu_new_ctrl_o;
  logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_o;
  logic [REG_ADDR_WIDTH-1:0] lsu_regdest_o;

  logic [32:0] stim_q[$];   // {valid, instruction}
  logic [31:0] pc;
  int          cycles;
  int          limit;

  rv_decoder u_rv_decoder (.*);

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  function automatic logic is_legal(input logic [6:0] opc);
    return opc inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
                       OPCODE_LOAD, OPCODE_STORE, OPCODE_JAL};
  endfunction

  task automatic push_instr(input logic [31:0] word);
    stim_q.push_back({1'b1, word});
  endtask

  task automatic push_idle(input int n);
    repeat (n) stim_q.push_back(33'h0);
  endtask

  // Random fields under a legal opcode, with the odd idle gap
  task automatic push_random(input int n);
    logic [6:0]  ops [7];
    logic [31:0] rnd;
    ops = '{OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
            OPCODE_LOAD, OPCODE_STORE, OPCODE_JAL};
    for (int k = 0; k < n; k++) begin
      rnd = $urandom();
      push_instr({rnd[31:7], ops[$urandom() % 7]});
      if ($urandom() % 4 == 0) push_idle(1);
    end
  endtask

  // Holds the word while the stage pushes back
  task automatic send(input logic [32:0] item);
    logic done;
    done = 1'b0;
    while (!done) begin
      instr_valid_i = item[32];
      instr_i       = item[31:0];
      instr_addr_i  = pc;
      @(negedge clk_i);
      done = !item[32] || ready_o || !is_legal(item[6:0]);  // Fetch drops illegal words
      @(posedge clk_i);
      #10;
    end
    pc = pc + 32'd4;
  endtask

  //////////////////////////////////////////////////
  // Watchdog and checker flag
  //////////////////////////////////////////////////
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (u_rv_decoder.u_rv_decoder_chk.failed) begin
      $display("FAIL at %0t: decoder checker assertion failed", $time);
      $display("Simulation FAILED");
      $fatal(1, "Stopped on first checker error");
    end else if (cycles >= limit) begin
      $display("Timeout after %0d cycles, stimulus did not complete", cycles);
      $display("Simulation FAILED");
      $fatal(1, "Stopped on timeout");
    end
  end

  initial begin
    void'($urandom(32'h9ea9_0a5b));
    clk_i         = 1'b0;
    rstn_i        = 1'b0;
    instr_i       = '0;
    instr_addr_i  = '0;
    instr_valid_i = 1'b0;
    cycles        = 0;
    pc            = 32'h0000_1000;

    push_idle(2);
    push_instr(u_type(20'habcde, 5'd5, OPCODE_LUI));
    push_instr(u_type(20'h12345, 5'd6, OPCODE_AUIPC));
    push_instr(i_type(12'hffd, 5'd0, 3'b000, 5'd7, OPCODE_OPIMM));            // ADDI
    push_instr(i_type({7'b0100000, 5'd7}, 5'd2, 3'b101, 5'd8, OPCODE_OPIMM)); // SRAI
    push_instr(i_type({7'b0, 5'd31}, 5'd3, 3'b001, 5'd9, OPCODE_OPIMM));      // SLLI
    push_instr(i_type(12'h008, 5'd4, 3'b010, 5'd10, OPCODE_LOAD));
    push_instr(s_type(12'hff4, 5'd11, 5'd12, 3'b010));
    push_instr(r_type(7'h00, 5'd15, 5'd14, 3'b000, 5'd13));   // Producer
    push_instr(r_type(7'h20, 5'd17, 5'd13, 3'b000, 5'd16));   // Consumer, stalls
    push_instr(r_type(7'h00, 5'd16, 5'd16, 3'b110, 5'd18));   // Stalls again
    push_idle(1);
    push_instr(j_type(21'h1ff800, 5'd1));
    push_idle(1);
    push_instr(32'h0000_0063);                                // BRANCH is illegal here
    push_idle(2);
    push_instr(i_type(12'h001, 5'd1, 3'b000, 5'd1, OPCODE_OPIMM));
    push_random(16);
    push_idle(2);
    limit = 2 * stim_q.size() + 20;

    repeat (3) @(posedge clk_i);
    #10;
    rstn_i = 1'b1;
    foreach (stim_q[k]) send(stim_q[k]);

    if (u_rv_decoder.u_rv_decoder_chk.failed) begin
      $display("FAIL at %0t: decoder checker assertion failed", $time);
      $display("Simulation FAILED");
      $fatal(1, "Checker reported an error");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: sim.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/dec_ctrl_if.sv
src/imm_gen.sv
src/opcode_decoder.sv
src/hazard_fsm.sv
src/issue_reg.sv
src/rv_decoder.sv
testbench/rv_decoder_chk.sv
testbench/tb_rv_decoder.sv

// File: Bender.yml
package:
  name: rv_decoder

sources:
  - src/rv_isa_pkg.sv
  - src/rv_ctrl_pkg.sv
  - src/dec_ctrl_if.sv
  - src/imm_gen.sv
  - src/opcode_decoder.sv
  - src/hazard_fsm.sv
  - src/issue_reg.sv
  - src/rv_decoder.sv
  - target: test
    files:
      - testbench/rv_decoder_chk.sv
      - testbench/tb_rv_decoder.sv
